// ==== logic/dma_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA front end package
// Address, length and request types shared by the DMA blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package dma_pkg;

  // Address and byte count widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 16;

  // One TCDM bank word
  localparam int unsigned BankBytes = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [LenWidth-1:0]  len_t;

  // 1-D copy request, also used for pieces and group chunks
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } dma_req_t;

  // Output of the splitter
  typedef struct packed {
    dma_req_t req;
    // Final piece of its request
    logic     last;
  } dma_piece_t;

endpackage : dma_pkg

`default_nettype wire

// ==== logic/dma_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA FIFO
// Circular valid/ready buffer for any payload type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 2
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  T                    mem [Depth];
  logic [PtrWidth-1:0] wr_ptr;
  logic [PtrWidth-1:0] rd_ptr;
  logic [CntWidth-1:0] count;
  logic                push;
  logic                pop;

  assign ready_o = (count != CntWidth'(Depth));
  assign valid_o = (count != '0);
  assign data_o  = mem[rd_ptr];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PtrWidth'(Depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PtrWidth'(Depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Fill level only moves when one side fires alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule : dma_fifo

`default_nettype wire

// ==== logic/dma_split.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA region splitter
// Cuts requests at interleaved TCDM region boundaries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_split #(
  parameter int unsigned NumGroups     = 4,
  parameter int unsigned BanksPerGroup = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // Incoming requests
  input  dma_pkg::dma_req_t   req_i,
  input  logic                valid_i,
  output logic                ready_o,
  // Outgoing pieces
  output dma_pkg::dma_piece_t piece_o,
  output logic                valid_o,
  input  logic                ready_i
);

  localparam int unsigned GroupBytes  = BanksPerGroup * dma_pkg::BankBytes;
  localparam int unsigned RegionBytes = NumGroups * GroupBytes;

  // Bytes of the head request already sent on
  dma_pkg::len_t  offset_q;

  dma_pkg::addr_t cur_src;
  dma_pkg::addr_t cur_dst;
  dma_pkg::addr_t to_boundary;
  dma_pkg::len_t  remaining;
  dma_pkg::len_t  piece_len;
  logic           last_piece;
  logic           fire;

  always_comb begin
    cur_src     = req_i.src + dma_pkg::addr_t'(offset_q);
    cur_dst     = req_i.dst + dma_pkg::addr_t'(offset_q);
    remaining   = req_i.num_bytes - offset_q;
    // Distance to the next region boundary, a full region when aligned
    to_boundary = dma_pkg::addr_t'(RegionBytes)
                  - (cur_dst % dma_pkg::addr_t'(RegionBytes));
    last_piece  = (dma_pkg::addr_t'(remaining) <= to_boundary);
    piece_len   = last_piece ? remaining : dma_pkg::len_t'(to_boundary);
  end

  always_comb begin
    piece_o.req.src       = cur_src;
    piece_o.req.dst       = cur_dst;
    piece_o.req.num_bytes = piece_len;
    piece_o.last          = last_piece;
  end

  assign valid_o = valid_i;
  assign fire    = valid_i & ready_i;

  // Request leaves the input buffer with its final piece
  assign ready_o = fire & last_piece;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      offset_q <= '0;
    end else if (fire) begin
      if (last_piece) begin
        offset_q <= '0;
      end else begin
        offset_q <= offset_q + piece_len;
      end
    end
  end

endmodule : dma_split

`default_nettype wire

// ==== logic/dma_distribute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA group distributor
// Cuts pieces into group chunks and routes them by destination
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_distribute #(
  parameter int unsigned NumGroups     = 4,
  parameter int unsigned BanksPerGroup = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Pieces from the splitter
  input  dma_pkg::dma_piece_t                 piece_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  // Room in the tracker for one more request
  input  logic                                trk_ready_i,
  // Group ports
  output dma_pkg::dma_req_t   [NumGroups-1:0] grp_req_o,
  output logic                [NumGroups-1:0] grp_valid_o,
  input  logic                [NumGroups-1:0] grp_ready_i,
  // Chunk strobes for the tracker
  output logic                                chunk_fire_o,
  output logic                                chunk_last_o
);

  localparam int unsigned GroupBytes = BanksPerGroup * dma_pkg::BankBytes;
  localparam int unsigned GroupShift = $clog2(GroupBytes);
  localparam int unsigned SelWidth   = (NumGroups > 1) ? $clog2(NumGroups) : 1;

  // Bytes of the current piece already handed out
  dma_pkg::len_t         offset_q;

  dma_pkg::dma_req_t     chunk;
  dma_pkg::addr_t        cur_dst;
  dma_pkg::addr_t        to_boundary;
  dma_pkg::addr_t        grp_idx;
  dma_pkg::len_t         remaining;
  logic                  chunk_end;
  logic                  chunk_last;
  logic                  chunk_valid;
  logic [SelWidth-1:0]   sel;
  logic                  fire;

  always_comb begin
    cur_dst     = piece_i.req.dst + dma_pkg::addr_t'(offset_q);
    remaining   = piece_i.req.num_bytes - offset_q;
    // Group slices are a power of two in size
    to_boundary = dma_pkg::addr_t'(GroupBytes)
                  - (cur_dst & dma_pkg::addr_t'(GroupBytes - 1));
    chunk_end   = (dma_pkg::addr_t'(remaining) <= to_boundary);
    chunk_last  = chunk_end & piece_i.last;

    chunk.src       = piece_i.req.src + dma_pkg::addr_t'(offset_q);
    chunk.dst       = cur_dst;
    chunk.num_bytes = chunk_end ? remaining : dma_pkg::len_t'(to_boundary);

    // Slices interleave over the groups
    grp_idx = (cur_dst >> GroupShift) % dma_pkg::addr_t'(NumGroups);
    sel     = SelWidth'(grp_idx);
  end

  // Final chunk waits for a free tracker slot
  assign chunk_valid = valid_i & (~chunk_last | trk_ready_i);

  always_comb begin
    for (int g = 0; g < NumGroups; g++) begin
      grp_req_o[g]   = chunk;
      grp_valid_o[g] = chunk_valid & (sel == SelWidth'(g));
    end
  end

  assign fire         = chunk_valid & grp_ready_i[sel];
  assign ready_o      = fire & chunk_end;
  assign chunk_fire_o = fire;
  assign chunk_last_o = fire & chunk_last;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      offset_q <= '0;
    end else if (fire) begin
      if (chunk_end) begin
        offset_q <= '0;
      end else begin
        offset_q <= offset_q + chunk.num_bytes;
      end
    end
  end

endmodule : dma_distribute

`default_nettype wire

// ==== logic/dma_tracker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA completion tracker
// Turns group completions into one done pulse per request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_tracker #(
  parameter int unsigned NumGroups      = 4,
  parameter int unsigned TransFifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 chunk_fire_i,
  input  logic                 chunk_last_i,
  output logic                 trk_ready_o,
  input  logic [NumGroups-1:0] grp_done_i,
  output logic                 done_o,
  output logic                 busy_o
);

  localparam int unsigned PopWidth = $clog2(NumGroups + 1);
  // Completions may run ahead of every request in flight
  localparam int unsigned AccWidth = dma_pkg::LenWidth + $clog2(TransFifoDepth + 2);

  dma_pkg::len_t       cnt_q;
  dma_pkg::len_t       head_cnt;
  logic                head_valid;
  logic [AccWidth-1:0] acc_q;
  logic [AccWidth-1:0] acc_sum;
  logic [PopWidth-1:0] done_cnt;
  logic                push;
  logic                pop;
  logic                done_q;
  logic                busy_q;

  always_comb begin
    done_cnt = '0;
    for (int g = 0; g < NumGroups; g++) begin
      done_cnt = done_cnt + PopWidth'(grp_done_i[g]);
    end
    acc_sum = acc_q + AccWidth'(done_cnt);
  end

  assign push = chunk_fire_i & chunk_last_i;
  assign pop  = head_valid & (acc_sum >= AccWidth'(head_cnt));

  // Chunk totals of requests in flight, oldest at the head
  dma_fifo #(
    .T    (dma_pkg::len_t),
    .Depth(TransFifoDepth)
  ) i_count_fifo (
    .clk_i  (clk_i       ),
    .rst_i  (rst_i       ),
    .data_i (cnt_q + 1'b1),
    .valid_i(push        ),
    .ready_o(trk_ready_o ),
    .data_o (head_cnt    ),
    .valid_o(head_valid  ),
    .ready_i(pop         )
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      acc_q  <= '0;
      done_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (chunk_fire_i) begin
        cnt_q <= chunk_last_i ? '0 : cnt_q + 1'b1;
      end
      acc_q  <= pop ? acc_sum - AccWidth'(head_cnt) : acc_sum;
      done_q <= pop;
      // Idle once the last request in flight has reported
      if (chunk_fire_i) begin
        busy_q <= 1'b1;
      end else if (done_q && !head_valid && cnt_q == '0) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign done_o = done_q;
  assign busy_o = busy_q;

endmodule : dma_tracker

`default_nettype wire

// ==== logic/dma_frontend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA request front end
// Buffers, splits and distributes copy requests to the groups
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_frontend #(
  parameter int unsigned NumGroups      = 4,
  parameter int unsigned BanksPerGroup  = 4,
  parameter int unsigned TransFifoDepth = 4,
  parameter int unsigned ReqFifoDepth   = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Copy requests
  input  dma_pkg::dma_req_t                 req_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  // Group ports
  output dma_pkg::dma_req_t [NumGroups-1:0] grp_req_o,
  output logic              [NumGroups-1:0] grp_valid_o,
  input  logic              [NumGroups-1:0] grp_ready_i,
  input  logic              [NumGroups-1:0] grp_done_i,
  // Status
  output logic                              done_o,
  output logic                              busy_o
);

  dma_pkg::dma_req_t   req_q;
  logic                req_q_valid;
  logic                req_q_ready;
  dma_pkg::dma_piece_t piece;
  logic                piece_valid;
  logic                piece_ready;
  logic                chunk_fire;
  logic                chunk_last;
  logic                trk_ready;

  dma_fifo #(
    .T    (dma_pkg::dma_req_t),
    .Depth(ReqFifoDepth      )
  ) i_req_fifo (
    .clk_i  (clk_i      ),
    .rst_i  (rst_i      ),
    .data_i (req_i      ),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_o (req_q      ),
    .valid_o(req_q_valid),
    .ready_i(req_q_ready)
  );

  dma_split #(
    .NumGroups    (NumGroups    ),
    .BanksPerGroup(BanksPerGroup)
  ) i_split (
    .clk_i  (clk_i      ),
    .rst_i  (rst_i      ),
    .req_i  (req_q      ),
    .valid_i(req_q_valid),
    .ready_o(req_q_ready),
    .piece_o(piece      ),
    .valid_o(piece_valid),
    .ready_i(piece_ready)
  );

  dma_distribute #(
    .NumGroups    (NumGroups    ),
    .BanksPerGroup(BanksPerGroup)
  ) i_distribute (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .piece_i     (piece      ),
    .valid_i     (piece_valid),
    .ready_o     (piece_ready),
    .trk_ready_i (trk_ready  ),
    .grp_req_o   (grp_req_o  ),
    .grp_valid_o (grp_valid_o),
    .grp_ready_i (grp_ready_i),
    .chunk_fire_o(chunk_fire ),
    .chunk_last_o(chunk_last )
  );

  dma_tracker #(
    .NumGroups     (NumGroups     ),
    .TransFifoDepth(TransFifoDepth)
  ) i_tracker (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .chunk_fire_i(chunk_fire),
    .chunk_last_i(chunk_last),
    .trk_ready_o (trk_ready ),
    .grp_done_i  (grp_done_i),
    .done_o      (done_o    ),
    .busy_o      (busy_o    )
  );

  // Elaboration checks
  if (NumGroups < 1) begin : gen_check_groups
    $fatal(1, "[dma_frontend] NumGroups must be at least 1.");
  end

  if (BanksPerGroup < 1 || BanksPerGroup != 2**$clog2(BanksPerGroup)) begin : gen_check_banks
    $fatal(1, "[dma_frontend] BanksPerGroup must be a power of two.");
  end

endmodule : dma_frontend

`default_nettype wire

// ==== sim/dma_frontend_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA front end properties
// Group port handshakes and reset state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_frontend_props #(
  parameter int unsigned NumGroups = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              req_ready_o,
  input  dma_pkg::dma_req_t [NumGroups-1:0] grp_req_o,
  input  logic              [NumGroups-1:0] grp_valid_o,
  input  logic              [NumGroups-1:0] grp_ready_i,
  input  logic                              done_o,
  input  logic                              busy_o
);

  // One group port active at a time
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grp_valid_o))
    else $error("more than one group port valid");

  assert property (@(posedge clk_i)
    rst_i |=> (grp_valid_o == '0 && !done_o && !busy_o && req_ready_o))
    else $error("front end not idle after reset");

  // Chunk stays put until its group takes it
  for (genvar g = 0; g < NumGroups; g++) begin : gen_hold
    assert property (@(posedge clk_i) disable iff (rst_i)
      grp_valid_o[g] && !grp_ready_i[g] |=> grp_valid_o[g] && $stable(grp_req_o[g]))
      else $error("group %0d chunk dropped or changed while held", g);
  end

endmodule : dma_frontend_props

`default_nettype wire

// ==== sim/tb_dma_frontend.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA front end testbench
// File driven requests, group models and chunk checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_dma_frontend;

  localparam int NumGroups     = 4;
  localparam int BanksPerGroup = 4;
  localparam int ReqFifoDepth  = 2;
  localparam int GroupBytes    = BanksPerGroup * dma_pkg::BankBytes;
  localparam int MaxTests      = 32;

  logic                              clk_i;
  logic                              rst_i;
  dma_pkg::dma_req_t                 req_i;
  logic                              req_valid_i;
  logic                              req_ready_o;
  dma_pkg::dma_req_t [NumGroups-1:0] grp_req_o;
  logic              [NumGroups-1:0] grp_valid_o;
  logic              [NumGroups-1:0] grp_ready_i;
  logic              [NumGroups-1:0] grp_done_i;
  logic                              done_o;
  logic                              busy_o;

  // Four words per test: src, dst, bytes, chunk count
  logic [31:0] test_mem [4*MaxTests];
  int          num_tests;
  int          seed;
  int          cyc;
  int          cyc_limit;
  int          errors;
  int          accepted;
  int          issued;
  int          done_seen;
  int          taken_total;
  int          done_applied;
  int          taken_cnt [MaxTests];
  int          taken_bytes [MaxTests];
  int          cum_chunks [MaxTests];

  // Expected chunk stream in request order
  logic [31:0] exp_src [$];
  logic [31:0] exp_dst [$];
  int          exp_len [$];
  int          exp_grp [$];
  int          exp_req [$];
  // Pending completions per taken chunk
  int          due_cyc [$];
  int          due_grp [$];

  dma_frontend #(
    .NumGroups    (NumGroups    ),
    .BanksPerGroup(BanksPerGroup),
    .ReqFifoDepth (ReqFifoDepth )
  ) dut (
    .clk_i, .rst_i, .req_i, .req_valid_i, .req_ready_o,
    .grp_req_o, .grp_valid_o, .grp_ready_i, .grp_done_i,
    .done_o, .busy_o
  );

  bind dma_frontend dma_frontend_props #(.NumGroups(NumGroups)) i_props (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_ready_o(req_ready_o),
    .grp_req_o  (grp_req_o  ),
    .grp_valid_o(grp_valid_o),
    .grp_ready_i(grp_ready_i),
    .done_o     (done_o     ),
    .busy_o     (busy_o     )
  );

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
    errors++;
  endtask

  // A region edge is also a slice edge, so cutting at slices covers both
  task automatic build_chunks(input int k);
    logic [31:0] src;
    logic [31:0] dst;
    int          left;
    int          len;
    int          n;
    src  = test_mem[4*k];
    dst  = test_mem[4*k+1];
    left = test_mem[4*k+2];
    n    = 0;
    while (left > 0) begin
      len = GroupBytes - (dst % GroupBytes);
      if (len > left) begin
        len = left;
      end
      exp_src.push_back(src);
      exp_dst.push_back(dst);
      exp_len.push_back(len);
      exp_grp.push_back((dst / GroupBytes) % NumGroups);
      exp_req.push_back(k);
      src  = src + len;
      dst  = dst + len;
      left = left - len;
      n++;
    end
    cum_chunks[k] = (k == 0) ? n : cum_chunks[k-1] + n;
    assert (n == test_mem[4*k+3])
      else report_mismatch($sformatf("test %0d chunk count", k), test_mem[4*k+3], n);
  endtask

  task automatic check_chunk(input int g);
    dma_pkg::dma_req_t got;
    int                k;
    int                e_grp;
    int                e_len;
    logic [31:0]       e_src;
    logic [31:0]       e_dst;
    got = grp_req_o[g];
    assert (exp_req.size() > 0)
      else report_error($sformatf("group %0d took a chunk beyond the expected ones", g));
    if (exp_req.size() > 0) begin
      k     = exp_req.pop_front();
      e_grp = exp_grp.pop_front();
      e_len = exp_len.pop_front();
      e_src = exp_src.pop_front();
      e_dst = exp_dst.pop_front();
      assert (g == e_grp) else report_mismatch("grp_valid_o index", e_grp, g);
      assert (got.src == e_src) else report_mismatch("grp_req_o.src", e_src, got.src);
      assert (got.dst == e_dst) else report_mismatch("grp_req_o.dst", e_dst, got.dst);
      assert (got.num_bytes == e_len)
        else report_mismatch("grp_req_o.num_bytes", e_len, got.num_bytes);
      assert ((got.dst % GroupBytes) + got.num_bytes <= GroupBytes)
        else report_error("chunk crosses a group slice boundary");
      taken_cnt[k]++;
      taken_bytes[k] += got.num_bytes;
      taken_total++;
      due_cyc.push_back(cyc + ({$random(seed)} % 8));
      due_grp.push_back(g);
      if (taken_cnt[k] == test_mem[4*k+3]) begin
        assert (taken_bytes[k] == test_mem[4*k+2])
          else report_mismatch("byte sum of chunks", test_mem[4*k+2], taken_bytes[k]);
        issued++;
      end
    end
  endtask

  task automatic check_done();
    assert (done_seen < num_tests) else report_error("done_o pulsed with no request in flight");
    if (done_seen < num_tests) begin
      assert (done_applied >= cum_chunks[done_seen])
        else report_error($sformatf("done_o for test %0d before its chunks completed", done_seen));
      $display("test %0d finished at cycle %0d: %0d chunks, errors so far %0d",
               done_seen, cyc, test_mem[4*done_seen+3], errors);
      done_seen++;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Group models answer taken chunks after a random delay
  initial begin : group_model
    logic [NumGroups-1:0] pulse;
    int                   i;
    forever begin
      @(posedge clk_i);
      #0.5;
      pulse = '0;
      i     = 0;
      while (i < due_cyc.size()) begin
        if (due_cyc[i] <= cyc && !pulse[due_grp[i]]) begin
          pulse[due_grp[i]] = 1'b1;
          due_cyc.delete(i);
          due_grp.delete(i);
        end else begin
          i++;
        end
      end
      grp_done_i = pulse;
      for (int g = 0; g < NumGroups; g++) begin
        grp_ready_i[g] = ($random(seed) % 4) != 0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      cyc++;
      if (cyc > cyc_limit) begin
        $display("timeout after %0d cycles, %0d of %0d tests done", cyc, done_seen, num_tests);
        $display("Something failed");
        $finish;
      end else begin
        // Input buffer frees a slot when a request's last chunk leaves
        assert (req_ready_o == (accepted - issued < ReqFifoDepth))
          else report_mismatch("req_ready_o", accepted - issued < ReqFifoDepth, req_ready_o);
        if (taken_total > done_applied) begin
          assert (busy_o) else report_error("busy_o low while chunks are outstanding");
        end
        if (done_o) begin
          check_done();
        end
        for (int g = 0; g < NumGroups; g++) begin
          if (grp_valid_o[g] && grp_ready_i[g]) begin
            check_chunk(g);
          end
        end
        if (req_valid_i && req_ready_o) begin
          accepted++;
        end
        done_applied += $countones(grp_done_i);
      end
    end
  end

  initial begin
    seed         = 62338;
    errors       = 0;
    cyc          = 0;
    accepted     = 0;
    issued       = 0;
    done_seen    = 0;
    taken_total  = 0;
    done_applied = 0;
    rst_i        = 1'b1;
    req_i        = '0;
    req_valid_i  = 1'b0;
    grp_ready_i  = '0;
    grp_done_i   = '0;
    for (int i = 0; i < 4*MaxTests; i++) begin
      test_mem[i] = '0;
    end
    for (int i = 0; i < MaxTests; i++) begin
      taken_cnt[i]   = 0;
      taken_bytes[i] = 0;
    end
    $readmemh("sim/dma_tests.txt", test_mem);
    num_tests = 0;
    while (num_tests < MaxTests && test_mem[4*num_tests+2] != 0) begin
      build_chunks(num_tests);
      num_tests++;
    end
    cyc_limit = 200 * num_tests + 100;

    repeat (4) @(posedge clk_i);
    #0.5;
    rst_i = 1'b0;
    assert (grp_valid_o == '0 && !done_o && !busy_o && req_ready_o)
      else report_error("front end not idle after reset");

    for (int k = 0; k < num_tests; k++) begin
      req_i.src       = test_mem[4*k];
      req_i.dst       = test_mem[4*k+1];
      req_i.num_bytes = test_mem[4*k+2][15:0];
      req_valid_i     = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!req_ready_o);
      #0.5;
    end
    req_valid_i = 1'b0;

    while (done_seen < num_tests) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    assert (!busy_o) else report_error("busy_o still high after the final done_o");
    assert (exp_req.size() == 0)
      else report_error($sformatf("%0d expected chunks never appeared", exp_req.size()));

    $display("tests %0d, done pulses %0d, chunks %0d, errors %0d",
             num_tests, done_seen, taken_total, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tb_dma_frontend

`default_nettype wire

// ==== sim/dma_tests.txt ====
// One request per line, all hex
// src      dst      bytes  chunks
00010000 00000000 0040 4
00010100 00000004 000c 1
00010200 0000000a 0020 3
00010300 0000003c 0008 2
00010400 00000100 0001 1
00010501 00000023 0064 7
00010600 00000200 0010 1
00010700 00000041 0003 1
00010800 0000007f 0002 2
00010900 00000010 0030 3
00020000 00001234 002d 4
00030006 00000008 0080 9

// ==== tb.f ====
logic/dma_pkg.sv
logic/dma_fifo.sv
logic/dma_split.sv
logic/dma_distribute.sv
logic/dma_tracker.sv
logic/dma_frontend.sv
sim/dma_frontend_props.sv
sim/tb_dma_frontend.sv

// ==== Bender.yml ====
package:
  name: dma_frontend

sources:
  - logic/dma_pkg.sv
  - logic/dma_fifo.sv
  - logic/dma_split.sv
  - logic/dma_distribute.sv
  - logic/dma_tracker.sv
  - logic/dma_frontend.sv
  - target: simulation
    files:
      - sim/dma_frontend_props.sv
      - sim/tb_dma_frontend.sv
